/* flist.f */
cache_pkg.sv
cache_ctrl_if.sv
cache_meta_array.sv
cache_ctrl.sv
cache_dpath.sv
blocking_cache.sv
tb_mem_model.sv
tb_blocking_cache.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and search the log for failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_blocking_cache -f flist.f \
  && ./obj_dir/Vtb_blocking_cache > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

/* tb_blocking_cache.sv */
// Testbench for the blocking cache
// Directed and random accesses checked against a reference cache model
`timescale 1ns/1ns

module tb_blocking_cache;
  import cache_pkg::*;

  localparam int TIMEOUT_NS = 500 * 80 * 4;  // Transactions x cycles x period

  logic  clk;
  logic  reset;
  logic  cachereq_val;
  logic  cachereq_rdy;
  logic  cachereq_type;
  addr_t cachereq_addr;
  word_t cachereq_data;
  logic  cacheresp_val;
  logic  cacheresp_rdy = 1'b1;
  word_t cacheresp_data;
  logic  cacheresp_hit;
  logic  memreq_val;
  logic  memreq_rdy;
  logic  memreq_type;
  addr_t memreq_addr;
  line_t memreq_data;
  logic  memresp_val;
  logic  memresp_rdy;
  line_t memresp_data;
  int    wr_count;
  addr_t wr_addr;
  line_t wr_line;

  // Reference cache state
  word_t ref_mem [addr_t];  // Latest value of each written word
  tag_t  ref_tag   [2][NUM_SETS];
  logic  ref_valid [2][NUM_SETS];
  logic  ref_dirty [2][NUM_SETS];
  logic  ref_lru   [NUM_SETS];
  int    exp_wb_count;

  addr_t exp_addr_q [$];
  word_t exp_data_q [$];
  logic  exp_hit_q  [$];

  int    seed = 32'h576e_76ca;
  int    rdy_seed = 32'h576e_76ca;
  logic  [31:0] rdy_rnd;
  logic  rand_rdy;
  int    cycle = 0;
  int    issued;
  int    resp_count = 0;
  int    accept_cycle;
  int    last_resp_cycle;
  int    check_errors;
  int    resp_errors = 0;
  addr_t got_addr;
  word_t got_data;
  logic  got_hit;

  blocking_cache i_dut (.*);

  tb_mem_model i_mem (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------

  // Same fill as the memory model
  function automatic word_t expected_fill(input addr_t a);
    return (a * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
  endfunction

  function automatic word_t current_word(input addr_t a);
    addr_t wa;
    wa = {a[31:2], 2'b00};
    if (ref_mem.exists(wa)) begin
      return ref_mem[wa];
    end
    return expected_fill(wa);
  endfunction

  function automatic void predict_access(input logic wr, input addr_t a, input word_t d,
                                         output word_t exp_d, output logic exp_h);
    idx_t idx;
    tag_t tag;
    logic hit_0;
    logic hit_1;
    logic way;
    idx   = a[OFF_BITS +: IDX_BITS];
    tag   = a[31 -: TAG_BITS];
    hit_0 = ref_valid[0][idx] && (ref_tag[0][idx] == tag);
    hit_1 = ref_valid[1][idx] && (ref_tag[1][idx] == tag);
    if (hit_0) begin
      way = 1'b0;
    end else if (hit_1) begin
      way = 1'b1;
    end else begin
      way = ref_lru[idx];  // Miss replaces the LRU way
      if (ref_valid[way][idx] && ref_dirty[way][idx]) begin
        exp_wb_count++;
      end
      ref_tag[way][idx]   = tag;
      ref_valid[way][idx] = 1'b1;
      ref_dirty[way][idx] = 1'b0;
    end
    ref_lru[idx] = ~way;
    exp_h = hit_0 | hit_1;
    if (wr) begin
      ref_dirty[way][idx] = 1'b1;
      ref_mem[{a[31:2], 2'b00}] = d;
      exp_d = '0;
    end else begin
      exp_d = current_word(a);
    end
  endfunction

  // One request and its response
  task automatic access(input logic wr, input addr_t a, input word_t d);
    word_t exp_d;
    logic  exp_h;
    cachereq_val  <= 1'b1;
    cachereq_type <= wr;
    cachereq_addr <= a;
    cachereq_data <= d;
    @(posedge clk);
    while (!cachereq_rdy) @(posedge clk);
    accept_cycle = cycle;
    predict_access(wr, a, d, exp_d, exp_h);
    exp_addr_q.push_back(a);
    exp_data_q.push_back(exp_d);
    exp_hit_q.push_back(exp_h);
    issued++;
    cachereq_val <= 1'b0;
    while (resp_count < issued) @(posedge clk);
  endtask

  // ------------------------------------------------------------------------
  // Response checker
  // ------------------------------------------------------------------------

  always @(posedge clk) begin
    if (!reset && cacheresp_val && cacheresp_rdy) begin
      if (exp_data_q.size() == 0) begin
        $display("unexpected response at %0t ns with no request outstanding", $time);
        resp_errors++;
      end else begin
        got_addr = exp_addr_q.pop_front();
        got_data = exp_data_q.pop_front();
        got_hit  = exp_hit_q.pop_front();
        if (cacheresp_data !== got_data) begin
          $display("mismatch at %0t ns: data for %h is %h, expected %h",
                   $time, got_addr, cacheresp_data, got_data);
          resp_errors++;
        end
        if (cacheresp_hit !== got_hit) begin
          $display("mismatch at %0t ns: hit for %h is %b, expected %b",
                   $time, got_addr, cacheresp_hit, got_hit);
          resp_errors++;
        end
      end
      resp_count      <= resp_count + 1;
      last_resp_cycle <= cycle;
    end
    rdy_rnd = $random(rdy_seed);
    cacheresp_rdy <= rand_rdy ? rdy_rnd[0] : 1'b1;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the cache stopped answering before the tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------

  initial begin
    logic [31:0] r;
    word_t       d;
    int          wb_before;
    line_t       exp_line;
    for (int s = 0; s < NUM_SETS; s++) begin
      ref_lru[s] = 1'b0;
      for (int w = 0; w < 2; w++) begin
        ref_tag[w][s]   = '0;
        ref_valid[w][s] = 1'b0;
        ref_dirty[w][s] = 1'b0;
      end
    end
    exp_wb_count = 0;
    issued       = 0;
    check_errors = 0;
    reset         <= 1'b1;
    cachereq_val  <= 1'b0;
    cachereq_type <= 1'b0;
    cachereq_addr <= '0;
    cachereq_data <= '0;
    rand_rdy      <= 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    if (cacheresp_val !== 1'b0 || memreq_val !== 1'b0 || memresp_rdy !== 1'b0 ||
        cachereq_rdy !== 1'b1) begin
      $display("mismatch at %0t ns: after reset resp_val %b mreq_val %b mresp_rdy %b req_rdy %b",
               $time, cacheresp_val, memreq_val, memresp_rdy, cachereq_rdy);
      check_errors++;
    end

    // Read miss, then a hit on the same line
    access(1'b0, 32'h0000_0108, '0);
    access(1'b0, 32'h0000_0108, '0);
    if (last_resp_cycle - accept_cycle != 3) begin
      $display("mismatch at %0t ns: hit response %0d cycles after accept, expected 3",
               $time, last_resp_cycle - accept_cycle);
      check_errors++;
    end

    // Write one word and read back the whole line
    access(1'b1, 32'h0000_0224, 32'ha5c3_0224);
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      access(1'b0, 32'h0000_0220 + addr_t'(w * 4), '0);
    end

    // Three lines at set 5 so the third evicts the dirty first line
    wb_before = wr_count;
    access(1'b1, 32'h0000_1058, 32'hc0de_1058);
    access(1'b0, 32'h0000_2050, '0);
    access(1'b0, 32'h0000_3050, '0);
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      exp_line[w*32 +: 32] = current_word(32'h0000_1050 + addr_t'(w * 4));
    end
    if (wr_count != wb_before + 1 || wr_addr !== 32'h0000_1050 || wr_line !== exp_line) begin
      $display("mismatch at %0t ns: write-back %0d lines, last %h with %h",
               $time, wr_count - wb_before, wr_addr, wr_line);
      check_errors++;
    end
    access(1'b0, 32'h0000_1058, '0);

    // Random mix over two sets and four tags
    rand_rdy <= 1'b1;
    repeat (400) begin
      r = $random(seed);
      d = $random(seed);
      access(r[5], {23'h00_0200, r[1:0], 2'b00, r[2], r[4:3], 2'b00}, d);
    end

    if (exp_data_q.size() != 0) begin
      $display("%0d responses never arrived", exp_data_q.size());
      check_errors++;
    end
    if (wr_count != exp_wb_count) begin
      $display("mismatch at %0t ns: %0d write-backs, expected %0d",
               $time, wr_count, exp_wb_count);
      check_errors++;
    end

    $display("errors: %0d in responses, %0d in directed checks", resp_errors, check_errors);
    if (resp_errors + check_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tb_mem_model.sv */
// Testbench line memory
// Serves line reads and write-backs with random latency and random back-pressure
`timescale 1ns/1ns

module tb_mem_model (
  input  logic             clk,
  input  logic             reset,
  input  logic             memreq_val,
  output logic             memreq_rdy,
  input  logic             memreq_type,
  input  cache_pkg::addr_t memreq_addr,
  input  cache_pkg::line_t memreq_data,
  output logic             memresp_val,
  input  logic             memresp_rdy,
  output cache_pkg::line_t memresp_data,
  output int               wr_count,   // Write-backs seen so far
  output cache_pkg::addr_t wr_addr,    // Last write-back
  output cache_pkg::line_t wr_line
);
  import cache_pkg::*;

  line_t       mem [addr_t];  // Written lines by line address
  int          seed = 32'h576e_76ca;
  logic [31:0] rnd;
  logic        rdy_q = 1'b0;
  logic        val_q = 1'b0;
  line_t       data_q = '0;
  logic        busy;
  logic [2:0]  delay_q;
  line_t       resp_line;

  // Fill word, every address bit takes part
  function automatic word_t fill_word(input addr_t a);
    return (a * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
  endfunction

  function automatic line_t read_line(input addr_t la);
    line_t l;
    if (mem.exists(la)) begin
      return mem[la];
    end
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      l[w*32 +: 32] = fill_word(la + addr_t'(w * 4));
    end
    return l;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      rdy_q    <= 1'b0;
      val_q    <= 1'b0;
      busy     <= 1'b0;
      wr_count <= 0;
    end else if (val_q) begin
      if (memresp_rdy) begin
        val_q <= 1'b0;
      end
    end else if (busy) begin
      if (delay_q == 3'd0) begin
        val_q  <= 1'b1;
        data_q <= resp_line;
        busy   <= 1'b0;
      end else begin
        delay_q <= delay_q - 3'd1;
      end
    end else if (memreq_val && rdy_q) begin
      rnd = $random(seed);
      delay_q <= 3'(rnd % 32'd5);  // Answer 1 to 5 cycles later
      busy    <= 1'b1;
      rdy_q   <= 1'b0;
      if (memreq_type == MEM_WRITE) begin
        mem[memreq_addr] = memreq_data;
        wr_count  <= wr_count + 1;
        wr_addr   <= memreq_addr;
        wr_line   <= memreq_data;
        resp_line <= '0;
      end else begin
        resp_line <= read_line(memreq_addr);
      end
    end else begin
      rnd = $random(seed);
      rdy_q <= (rnd[1:0] != 2'b00);  // Ready about three cycles in four
    end
  end

  assign memreq_rdy   = rdy_q;
  assign memresp_val  = val_q;
  assign memresp_data = data_q;

endmodule

/* blocking_cache.sv */
// Blocking two-way write-back cache
// Controller and datapath joined by the control interface
`timescale 1ns/1ns

module blocking_cache (
  input  logic              clk,
  input  logic              reset,

  // Cache request
  input  logic              cachereq_val,
  output logic              cachereq_rdy,
  input  logic              cachereq_type,   // 0 read, 1 write
  input  cache_pkg::addr_t  cachereq_addr,
  input  cache_pkg::word_t  cachereq_data,

  // Cache response
  output logic              cacheresp_val,
  input  logic              cacheresp_rdy,
  output cache_pkg::word_t  cacheresp_data,
  output logic              cacheresp_hit,

  // Memory request, whole lines
  output logic              memreq_val,
  input  logic              memreq_rdy,
  output logic              memreq_type,
  output cache_pkg::addr_t  memreq_addr,
  output cache_pkg::line_t  memreq_data,

  // Memory response
  input  logic              memresp_val,
  output logic              memresp_rdy,
  input  cache_pkg::line_t  memresp_data
);

  cache_ctrl_if i_ctl_if ();

  cache_ctrl i_ctrl (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .cacheresp_hit (cacheresp_hit),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memreq_type   (memreq_type),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .ctl           (i_ctl_if.ctrl)
  );

  cache_dpath i_dpath (
    .clk            (clk),
    .reset          (reset),
    .cachereq_addr  (cachereq_addr),
    .cachereq_data  (cachereq_data),
    .cachereq_type  (cachereq_type),
    .cacheresp_data (cacheresp_data),
    .memreq_addr    (memreq_addr),
    .memreq_data    (memreq_data),
    .memresp_data   (memresp_data),
    .ctl            (i_ctl_if.dpath)
  );

endmodule

/* cache_dpath.sv */
// Cache datapath
// Request registers, two-way tag and data arrays, word merge, eviction and
// refill buffers, and memory address select
`timescale 1ns/1ns

module cache_dpath (
  input  logic              clk,
  input  logic              reset,
  input  cache_pkg::addr_t  cachereq_addr,
  input  cache_pkg::word_t  cachereq_data,
  input  logic              cachereq_type,
  output cache_pkg::word_t  cacheresp_data,
  output cache_pkg::addr_t  memreq_addr,
  output cache_pkg::line_t  memreq_data,
  input  cache_pkg::line_t  memresp_data,
  cache_ctrl_if.dpath       ctl
);
  import cache_pkg::*;

  // Request registers
  addr_t     req_addr;
  word_t     req_data;
  logic      req_type;
  tag_t      req_tag;
  idx_t      req_idx;
  word_off_t req_off;

  // Arrays, indexed [way][set]
  tag_t  tag_array  [2][NUM_SETS];
  line_t data_array [2][NUM_SETS];

  tag_t  rd_tag_0, rd_tag_1;
  line_t rd_line;
  word_t rd_word;
  line_t merged_line;
  line_t wr_line;

  line_t refill_line;
  line_t evict_line;
  addr_t evict_addr;
  word_t resp_q;

  // --------------------------------------------------------------------------
  // Request capture
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      req_type <= 1'b0;
    end else if (ctl.req_en) begin
      req_type <= cachereq_type;
    end
  end

  always_ff @(posedge clk) begin
    if (ctl.req_en) begin
      req_addr <= cachereq_addr;
      req_data <= cachereq_data;
    end
  end

  assign req_tag = req_addr[31 -: TAG_BITS];
  assign req_idx = req_addr[OFF_BITS +: IDX_BITS];
  assign req_off = req_addr[OFF_BITS-1:2];

  assign ctl.req_idx      = req_idx;
  assign ctl.req_is_write = req_type;

  // --------------------------------------------------------------------------
  // Tag and data arrays
  // --------------------------------------------------------------------------

  assign rd_tag_0 = tag_array[0][req_idx];
  assign rd_tag_1 = tag_array[1][req_idx];

  // Raw compares, valid bits live in the controller
  assign ctl.tag_match_0 = ctl.tag_ren && (rd_tag_0 == req_tag);
  assign ctl.tag_match_1 = ctl.tag_ren && (rd_tag_1 == req_tag);

  assign rd_line = ctl.data_ren ? data_array[ctl.way_sel][req_idx] : '0;
  assign rd_word = rd_line[req_off*32 +: 32];

  // Drop the write word into its slot, keep the rest of the line
  always_comb begin
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      if (word_off_t'(w) == req_off) begin
        merged_line[w*32 +: 32] = req_data;
      end else begin
        merged_line[w*32 +: 32] = rd_line[w*32 +: 32];
      end
    end
  end

  assign wr_line = ctl.refill_sel ? refill_line : merged_line;

  always_ff @(posedge clk) begin
    if (ctl.tag_wen) begin
      tag_array[ctl.way_sel][req_idx] <= req_tag;
    end
    if (ctl.data_wen) begin
      data_array[ctl.way_sel][req_idx] <= wr_line;
    end
  end

  // --------------------------------------------------------------------------
  // Eviction, refill and response buffers
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (ctl.evict_en) begin
      evict_line <= rd_line;
      evict_addr <= {(ctl.way_sel ? rd_tag_1 : rd_tag_0), req_idx, {OFF_BITS{1'b0}}};
    end
    if (ctl.memresp_en) begin
      refill_line <= memresp_data;
    end
    if (ctl.resp_en) begin
      resp_q <= req_type ? '0 : rd_word;  // Writes return zero
    end
  end

  assign cacheresp_data = resp_q;
  assign memreq_data    = evict_line;
  assign memreq_addr    = ctl.memreq_addr_sel ? evict_addr
                                              : {req_addr[31:OFF_BITS], {OFF_BITS{1'b0}}};

endmodule

/* cache_ctrl.sv */
// Cache controller
// FSM that resolves hit and victim, sequences evict and refill, and drives
// both val/rdy ports and all datapath strobes
`timescale 1ns/1ns

module cache_ctrl (
  input  logic          clk,
  input  logic          reset,
  input  logic          cachereq_val,
  output logic          cachereq_rdy,
  output logic          cacheresp_val,
  input  logic          cacheresp_rdy,
  output logic          cacheresp_hit,
  output logic          memreq_val,
  input  logic          memreq_rdy,
  output logic          memreq_type,
  input  logic          memresp_val,
  output logic          memresp_rdy,
  cache_ctrl_if.ctrl    ctl
);
  import cache_pkg::*;

  cache_state_e state_q;
  cache_state_e state_next;

  logic valid_0, valid_1, dirty_0, dirty_1, lru;
  logic valid_wen, dirty_set, dirty_clr, lru_wen;
  logic hit_0, hit_1, hit;
  logic victim_valid, victim_dirty;
  logic hit_q;
  logic way_q;      // Hit way, or victim way on a miss
  logic [17:0] cs;  // Control row

  cache_meta_array i_meta (
    .clk       (clk),
    .reset     (reset),
    .idx       (ctl.req_idx),
    .valid_0   (valid_0),
    .valid_1   (valid_1),
    .dirty_0   (dirty_0),
    .dirty_1   (dirty_1),
    .lru       (lru),
    .valid_wen (valid_wen),
    .dirty_set (dirty_set),
    .dirty_clr (dirty_clr),
    .way       (way_q),
    .lru_wen   (lru_wen)
  );

  // --------------------------------------------------------------------------
  // Hit and victim
  // --------------------------------------------------------------------------

  assign hit_0        = ctl.tag_match_0 & valid_0;
  assign hit_1        = ctl.tag_match_1 & valid_1;
  assign hit          = hit_0 | hit_1;
  assign victim_valid = lru ? valid_1 : valid_0;
  assign victim_dirty = lru ? dirty_1 : dirty_0;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
      hit_q   <= 1'b0;
      way_q   <= 1'b0;
    end else begin
      state_q <= state_next;
      if (state_q == ST_TAG_CHECK) begin
        hit_q <= hit;
        way_q <= hit_0 ? 1'b0 : (hit_1 ? 1'b1 : lru);
      end
    end
  end

  always_comb begin
    state_next = state_q;
    case (state_q)
      ST_IDLE: begin
        if (cachereq_val) begin
          state_next = ST_TAG_CHECK;
        end
      end
      ST_TAG_CHECK: begin
        if (hit) begin
          state_next = ctl.req_is_write ? ST_WRITE_ACCESS : ST_READ_ACCESS;
        end else if (victim_valid && victim_dirty) begin
          state_next = ST_EVICT_PREPARE;
        end else begin
          state_next = ST_REFILL_REQUEST;
        end
      end
      ST_READ_ACCESS:   state_next = ST_RESPOND;
      ST_WRITE_ACCESS:  state_next = ST_RESPOND;
      ST_EVICT_PREPARE: state_next = ST_EVICT_REQUEST;
      ST_EVICT_REQUEST: begin
        if (memreq_rdy) begin
          state_next = ST_EVICT_WAIT;
        end
      end
      ST_EVICT_WAIT: begin
        if (memresp_val) begin
          state_next = ST_REFILL_REQUEST;  // Write ack, go fetch the line
        end
      end
      ST_REFILL_REQUEST: begin
        if (memreq_rdy) begin
          state_next = ST_REFILL_WAIT;
        end
      end
      ST_REFILL_WAIT: begin
        if (memresp_val) begin
          state_next = ST_REFILL_UPDATE;
        end
      end
      ST_REFILL_UPDATE: begin
        state_next = ctl.req_is_write ? ST_WRITE_ACCESS : ST_READ_ACCESS;
      end
      ST_RESPOND: begin
        if (cacheresp_rdy) begin
          state_next = ST_IDLE;
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

  // --------------------------------------------------------------------------
  // Control table
  // --------------------------------------------------------------------------
  // Row groups, left to right
  //   ports: cachereq_rdy cacheresp_val memreq_val memresp_rdy
  //   dpath: req_en tag_ren tag_wen data_ren data_wen refill_sel evict_en
  //          memresp_en resp_en memreq_addr_sel
  //   meta:  valid_wen dirty_set dirty_clr lru_wen

  always_comb begin
    case (state_q)
      ST_IDLE:           cs = 18'b1000_1000000000_0000;
      ST_TAG_CHECK:      cs = 18'b0000_0100000000_0000;
      ST_READ_ACCESS:    cs = 18'b0000_0001000010_0001;
      ST_WRITE_ACCESS:   cs = 18'b0000_0001100010_1101;
      ST_EVICT_PREPARE:  cs = 18'b0000_0101001000_0000;
      ST_EVICT_REQUEST:  cs = 18'b0010_0000000001_0000;
      ST_EVICT_WAIT:     cs = 18'b0001_0000000000_0000;
      ST_REFILL_REQUEST: cs = 18'b0010_0000000000_0000;
      ST_REFILL_WAIT:    cs = 18'b0001_0000000100_0000;
      ST_REFILL_UPDATE:  cs = 18'b0000_0010110000_1010;
      ST_RESPOND:        cs = 18'b0100_0000000000_0000;
      default:           cs = '0;
    endcase
  end

  assign {cachereq_rdy, cacheresp_val, memreq_val, memresp_rdy} = cs[17:14];
  assign {ctl.req_en, ctl.tag_ren, ctl.tag_wen, ctl.data_ren, ctl.data_wen,
          ctl.refill_sel, ctl.evict_en, ctl.memresp_en, ctl.resp_en,
          ctl.memreq_addr_sel} = cs[13:4];
  assign {valid_wen, dirty_set, dirty_clr, lru_wen} = cs[3:0];

  assign memreq_type   = (state_q == ST_EVICT_REQUEST) ? MEM_WRITE : MEM_READ;
  assign ctl.way_sel   = way_q;
  assign cacheresp_hit = hit_q;

endmodule

/* cache_meta_array.sv */
// Cache meta state
// Valid and dirty bits per way and one LRU bit per set, all cleared on reset
`timescale 1ns/1ns

module cache_meta_array (
  input  logic            clk,
  input  logic            reset,
  input  cache_pkg::idx_t idx,
  output logic            valid_0,
  output logic            valid_1,
  output logic            dirty_0,
  output logic            dirty_1,
  output logic            lru,
  input  logic            valid_wen,
  input  logic            dirty_set,
  input  logic            dirty_clr,
  input  logic            way,
  input  logic            lru_wen
);
  import cache_pkg::*;

  logic [NUM_SETS-1:0] valid_q [2];
  logic [NUM_SETS-1:0] dirty_q [2];
  logic [NUM_SETS-1:0] lru_q;   // Points at the way to replace next

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q[0] <= '0;
      valid_q[1] <= '0;
      dirty_q[0] <= '0;
      dirty_q[1] <= '0;
      lru_q      <= '0;
    end else begin
      if (valid_wen) begin
        valid_q[way][idx] <= 1'b1;
      end
      // Set wins if both are asked for
      if (dirty_set) begin
        dirty_q[way][idx] <= 1'b1;
      end else if (dirty_clr) begin
        dirty_q[way][idx] <= 1'b0;
      end
      if (lru_wen) begin
        lru_q[idx] <= ~way;  // Other way becomes the victim
      end
    end
  end

  // Combinational reads at the request index
  assign valid_0 = valid_q[0][idx];
  assign valid_1 = valid_q[1][idx];
  assign dirty_0 = dirty_q[0][idx];
  assign dirty_1 = dirty_q[1][idx];
  assign lru     = lru_q[idx];

endmodule

/* cache_ctrl_if.sv */
// Controller to datapath link
// Strobes and selects go one way, tag compares and request fields come back
`timescale 1ns/1ns

interface cache_ctrl_if;
  import cache_pkg::*;

  // Driven by the controller
  logic req_en;           // Capture request registers
  logic tag_ren;
  logic tag_wen;
  logic data_ren;
  logic data_wen;
  logic way_sel;          // Way the access targets
  logic refill_sel;       // Memory line instead of merged word
  logic evict_en;         // Capture victim line and address
  logic memresp_en;       // Capture refill line
  logic resp_en;          // Capture read word
  logic memreq_addr_sel;  // 1 = victim address

  // Driven by the datapath
  logic tag_match_0;
  logic tag_match_1;
  idx_t req_idx;
  logic req_is_write;

  modport ctrl (
    output req_en, tag_ren, tag_wen, data_ren, data_wen, way_sel,
           refill_sel, evict_en, memresp_en, resp_en, memreq_addr_sel,
    input  tag_match_0, tag_match_1, req_idx, req_is_write
  );

  modport dpath (
    input  req_en, tag_ren, tag_wen, data_ren, data_wen, way_sel,
           refill_sel, evict_en, memresp_en, resp_en, memreq_addr_sel,
    output tag_match_0, tag_match_1, req_idx, req_is_write
  );

endinterface

/* cache_pkg.sv */
// Cache package
// Geometry, address fields, vector types and controller states for the
// two-way blocking cache
package cache_pkg;

  // --------------------------------------------------------------------------
  // Geometry
  // --------------------------------------------------------------------------

  localparam int WORDS_PER_LINE = 4;   // 16-byte lines
  localparam int NUM_SETS       = 8;   // Sets per way
  localparam int OFF_BITS       = 4;   // Byte offset in line
  localparam int IDX_BITS       = 3;
  localparam int TAG_BITS       = 25;  // 32 - IDX_BITS - OFF_BITS

  // Memory request types
  localparam logic MEM_READ  = 1'b0;
  localparam logic MEM_WRITE = 1'b1;

  // --------------------------------------------------------------------------
  // Vector types
  // --------------------------------------------------------------------------

  typedef logic [31:0]          addr_t;
  typedef logic [31:0]          word_t;
  typedef logic [127:0]         line_t;
  typedef logic [TAG_BITS-1:0]  tag_t;
  typedef logic [IDX_BITS-1:0]  idx_t;       // Address bits 6:4
  typedef logic [1:0]           word_off_t;  // Address bits 3:2

  // Controller states
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_TAG_CHECK,
    ST_READ_ACCESS,
    ST_WRITE_ACCESS,
    ST_EVICT_PREPARE,
    ST_EVICT_REQUEST,
    ST_EVICT_WAIT,
    ST_REFILL_REQUEST,
    ST_REFILL_WAIT,
    ST_REFILL_UPDATE,
    ST_RESPOND
  } cache_state_e;

endpackage
